/* sources.f */
+incdir+source
source/bridgePkg.sv
source/ahbSlaveInterface.sv
source/apbFsmController.sv
source/ahbApbBridge.sv
dv/apbPeripheralModel.sv
dv/bridgeTb.sv

/* dv/bridgeTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Bridge testbench. Hreadyout loops back to Hreadyin.
// Test addresses keep offsets below 1 KB to fit the peripheral model.
// ~~~~~~~~~~~~~~~~~~~~
`include "bridgeMacros_macros.svh"

module bridgeTb;
	import bridgePkg::*;

	localparam word_t fillKey   = 32'h5ac3_0f96;
	localparam int    waitLimit = 64;
	localparam int    memDepth  = 256;
	localparam addr_t slaveBase [`NUM_SLAVES] =
		'{`SLAVE0_BASE, `SLAVE1_BASE, `SLAVE2_BASE};

	logic    Hclk;
	logic    Hresetn;
	addr_t   Haddr;
	word_t   Hwdata;
	logic    Hwrite;
	htrans_t Htrans;
	logic    Hreadyout;
	word_t   Hrdata;
	addr_t   Paddr;
	word_t   Pwdata;
	logic    Pwrite;
	selx_t   Pselx;
	logic    Penable;
	word_t   Prdata;

	word_t shadow [`NUM_SLAVES][memDepth];
	logic  written [`NUM_SLAVES][memDepth];

	selx_t expSel [$];
	addr_t expAddr [$];
	word_t expData [$];
	logic  expWrite [$];

	int          errorCount;
	int          errorsAtStart;
	int          testsRun;
	int          testsFailed;
	int          logSeen;
	int          logStart;
	logic [31:0] lcgState;
	logic [31:0] r;
	int          win;

	ahbApbBridge dut0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.Hwrite    (Hwrite),
		.Htrans    (Htrans),
		.Hreadyin  (Hreadyout), // no interconnect, ready loops back.
		.Prdata    (Prdata),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Pwrite    (Pwrite),
		.Pselx     (Pselx),
		.Penable   (Penable)
	);

	apbPeripheralModel #(.fillKey(fillKey)) periph0
	(
		.Hclk    (Hclk),
		.Pselx   (Pselx),
		.Penable (Penable),
		.Pwrite  (Pwrite),
		.Paddr   (Paddr),
		.Pwdata  (Pwdata),
		.Prdata  (Prdata)
	);

	initial
	begin
		Hclk = 1'b0;
		forever
			#2 Hclk = ~Hclk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int windowOf(input addr_t addr);
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if ((addr - slaveBase[i]) < `SLAVE_SPAN)
				return i;
		end
		return -1;
	endfunction

	// last write to the address, else the model's fill value.
	function automatic word_t expectedRead(input addr_t addr);
		int w;
		w = windowOf(addr);
		if (w < 0)
			return '0;
		if (written[w][addr[9:2]])
			return shadow[w][addr[9:2]];
		return addr ^ fillKey;
	endfunction

	task automatic checkWord(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkAddr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkSel(input string what, input selx_t got, input selx_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
			errorCount++;
		end
	endtask

	// checks the current falling edge first.
	task automatic waitReady(input string phase);
		int n;
		n = 0;
		while (Hreadyout !== 1'b1 && n < waitLimit)
		begin
			@(negedge Hclk);
			n++;
		end
		if (Hreadyout !== 1'b1)
		begin
			$display("TIMEOUT at %0t: Hreadyout stayed low in the %s", $time, phase);
			errorCount++;
		end
	endtask

	task automatic waitDrained();
		int n;
		n = 0;
		while (expAddr.size() != 0 && n < waitLimit * 4)
		begin
			@(negedge Hclk);
			n++;
		end
		if (expAddr.size() != 0)
		begin
			$display("TIMEOUT at %0t: %0d APB transfers never completed", $time, expAddr.size());
			errorCount++;
			expSel.delete();
			expAddr.delete();
			expData.delete();
			expWrite.delete();
		end
	endtask

	task automatic expectXfer(input int w, input addr_t addr, input word_t data, input logic wr);
		expSel.push_back(selx_t'(1) << w);
		expAddr.push_back(addr);
		expData.push_back(data);
		expWrite.push_back(wr);
		if (wr)
		begin
			shadow[w][addr[9:2]]  = data;
			written[w][addr[9:2]] = 1'b1;
		end
	endtask

	// one transfer with an idle bus after it.
	task automatic issue(input logic wr, input addr_t addr, input word_t data, input htrans_t htr);
		int    w;
		word_t expRead;
		logic  live;
		w       = windowOf(addr);
		expRead = expectedRead(addr);
		live    = (w >= 0) && (htr == NONSEQ || htr == SEQ);
		@(negedge Hclk);
		waitReady("address phase");
		Haddr  = addr;
		Hwrite = wr;
		Htrans = htr;
		if (live)
			expectXfer(w, addr, wr ? data : expRead, wr);
		@(negedge Hclk);
		Htrans = IDLE;
		Hwrite = 1'b0;
		Hwdata = data;
		if (!live)
			checkFlag("Hreadyout for ignored transfer", Hreadyout, 1'b1);
		waitReady("data phase");
		if (live && !wr)
			checkWord("Hrdata", Hrdata, expRead);
	endtask

	// incrementing writes, each address overlapping the previous data phase.
	task automatic writeBurst(input addr_t start, input int count);
		addr_t addr;
		word_t data [$];
		addr = start;
		@(negedge Hclk);
		waitReady("burst start");
		for (int k = 0; k <= count; k++)
		begin
			if (k > 0)
			begin
				@(negedge Hclk);
				Hwdata = data[k-1];
			end
			if (k < count)
			begin
				data.push_back(nextRand());
				Haddr  = addr;
				Hwrite = 1'b1;
				Htrans = (k == 0) ? NONSEQ : SEQ;
				expectXfer(windowOf(addr), addr, data[k], 1'b1);
				addr = addr + 4;
			end
			else
			begin
				Htrans = IDLE;
				Hwrite = 1'b0;
			end
			waitReady("burst beat");
		end
	endtask

	task automatic endTest(input string name);
		waitDrained();
		testsRun++;
		if (errorCount != errorsAtStart)
		begin
			testsFailed++;
			$display("test %0d %s: FAIL, %0d errors", testsRun, name, errorCount - errorsAtStart);
		end
		else
			$display("test %0d %s: PASS", testsRun, name);
		errorsAtStart = errorCount;
	endtask

	// compares each logged APB transfer with the oldest expected one.
	initial
	begin
		logSeen = 0;
		forever
		begin
			@(negedge Hclk);
			while (logSeen < periph0.logAddr.size())
			begin
				if (expAddr.size() == 0)
				begin
					$display("ERROR at %0t: unexpected APB transfer to address %h",
						$time, periph0.logAddr[logSeen]);
					errorCount++;
				end
				else
				begin
					checkSel("logged select", periph0.logSel[logSeen], expSel.pop_front());
					checkAddr("logged address", periph0.logAddr[logSeen], expAddr.pop_front());
					checkWord("logged data", periph0.logData[logSeen], expData.pop_front());
					checkFlag("logged direction", periph0.logWrite[logSeen], expWrite.pop_front());
				end
				logSeen++;
			end
		end
	end

	initial
	begin
		Hresetn       = 1'b0;
		Haddr         = '0;
		Hwdata        = '0;
		Hwrite        = 1'b0;
		Htrans        = IDLE;
		lcgState      = 32'hd786;
		errorCount    = 0;
		errorsAtStart = 0;
		testsRun      = 0;
		testsFailed   = 0;
		for (int s = 0; s < `NUM_SLAVES; s++)
		begin
			for (int i = 0; i < memDepth; i++)
				written[s][i] = 1'b0;
		end

		for (int c = 0; c < 16; c++)
		begin
			@(negedge Hclk);
			checkSel("Pselx in reset", Pselx, '0);
			checkFlag("Penable in reset", Penable, 1'b0);
			checkFlag("Pwrite in reset", Pwrite, 1'b0);
		end
		Hresetn = 1'b1;
		@(negedge Hclk);
		checkSel("Pselx after reset", Pselx, '0);
		checkFlag("Penable after reset", Penable, 1'b0);
		checkFlag("Pwrite after reset", Pwrite, 1'b0);
		checkWord("log size after reset", word_t'(periph0.logAddr.size()), '0);
		endTest("reset");

		for (int w = 0; w < `NUM_SLAVES; w++)
			issue(1'b1, slaveBase[w] + 32'h8, nextRand(), NONSEQ);
		endTest("single writes");

		for (int w = 0; w < `NUM_SLAVES; w++)
			issue(1'b0, slaveBase[w] + 32'h8, '0, NONSEQ);
		endTest("single reads");

		writeBurst(slaveBase[1] + 32'h40, 4);
		endTest("back-to-back writes");

		logStart = periph0.logAddr.size();
		issue(1'b1, 32'h9000_0000, 32'h1234_5678, NONSEQ);
		issue(1'b0, 32'h7fff_fffc, '0, NONSEQ);
		issue(1'b1, slaveBase[2] + 32'h10, 32'hdead_beef, IDLE);
		for (int c = 0; c < 8; c++)
		begin
			@(negedge Hclk);
			checkFlag("Hreadyout when idle", Hreadyout, 1'b1);
		end
		checkWord("log size", word_t'(periph0.logAddr.size() - logStart), '0);
		endTest("ignored transfers");

		logStart = periph0.logAddr.size();
		for (int i = 0; i < 200; i++)
		begin
			r   = nextRand();
			win = int'(r[31:30]) % `NUM_SLAVES;
			issue(r[21], slaveBase[win] + {22'd0, r[29:22], 2'b00}, nextRand(), NONSEQ);
		end
		waitDrained();
		checkWord("log size", word_t'(periph0.logAddr.size() - logStart), word_t'(200));
		endTest("random traffic");

		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* dv/apbPeripheralModel.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Behavioural APB memory, 256 words per peripheral, no wait states.
// Only address bits 9:2 index a word, so higher offsets alias.
// ~~~~~~~~~~~~~~~~~~~~
`include "bridgeMacros_macros.svh"

module apbPeripheralModel
#(
	parameter bridgePkg::word_t fillKey = '0
)
(
	input  logic             Hclk,
	input  bridgePkg::selx_t Pselx,
	input  logic             Penable,
	input  logic             Pwrite,
	input  bridgePkg::addr_t Paddr,
	input  bridgePkg::word_t Pwdata,
	output bridgePkg::word_t Prdata
);
	import bridgePkg::*;

	localparam int memDepth = 256;
	localparam addr_t slaveBase [`NUM_SLAVES] =
		'{`SLAVE0_BASE, `SLAVE1_BASE, `SLAVE2_BASE};

	word_t mem [`NUM_SLAVES][memDepth];
	int    selIdx;

	// completed transfers, oldest first.
	selx_t logSel [$];
	addr_t logAddr [$];
	word_t logData [$];
	logic  logWrite [$];

	initial
	begin
		for (int s = 0; s < `NUM_SLAVES; s++)
		begin
			for (int i = 0; i < memDepth; i++)
				mem[s][i] = (slaveBase[s] + addr_t'(i * 4)) ^ fillKey;
		end
	end

	always_comb
	begin
		selIdx = 0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if (Pselx[i])
				selIdx = i;
		end
	end

	assign Prdata = (Pselx != '0) ? mem[selIdx][Paddr[9:2]] : '0;

	always @(posedge Hclk)
	begin
		if (Pselx != '0 && Penable)
		begin
			if (Pwrite)
				mem[selIdx][Paddr[9:2]] = Pwdata;
			logSel.push_back(Pselx);
			logAddr.push_back(Paddr);
			logData.push_back(Pwrite ? Pwdata : Prdata);
			logWrite.push_back(Pwrite);
		end
	end

endmodule

/* source/ahbApbBridge.sv */
// ~~~~~~~~~~~~~~~~~~~~
// AHB to APB bridge for three peripheral windows. Always answers OKAY.
// Hreadyin comes from the interconnect ready mux.
// ~~~~~~~~~~~~~~~~~~~~
module ahbApbBridge
(
	input  logic               Hclk,
	input  logic               Hresetn,
	input  bridgePkg::addr_t   Haddr,
	input  bridgePkg::word_t   Hwdata,
	input  logic               Hwrite,
	input  bridgePkg::htrans_t Htrans,
	input  logic               Hreadyin,
	input  bridgePkg::word_t   Prdata,
	output logic               Hreadyout,
	output bridgePkg::word_t   Hrdata,
	output bridgePkg::addr_t   Paddr,
	output bridgePkg::word_t   Pwdata,
	output logic               Pwrite,
	output bridgePkg::selx_t   Pselx,
	output logic               Penable
);
	import bridgePkg::*;

	logic  valid;
	logic  Hwritereg;
	addr_t Haddr1;
	addr_t Haddr2;
	selx_t tempselx;

	ahbSlaveInterface ahbSlave0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.Hwrite    (Hwrite),
		.Htrans    (Htrans),
		.Hreadyin  (Hreadyin),
		.valid     (valid),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (), // data stages unused, write data is taken live.
		.Hwdata2   (),
		.Hwritereg (Hwritereg),
		.tempselx  (tempselx)
	);

	apbFsmController apbCtrl0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.Hwrite    (Hwrite),
		.Hwritereg (Hwritereg),
		.Haddr     (Haddr),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata    (Hwdata),
		.tempselx  (tempselx),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Hreadyout (Hreadyout),
		.Pselx     (Pselx),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata)
	);

	assign Hrdata = Prdata; // valid in the read enable cycle.

endmodule

/* source/apbFsmController.sv */
// ~~~~~~~~~~~~~~~~~~~~
// APB transfer FSM with registered outputs. Reads take a fixed 2 cycles.
// Pready and Pslverr are not supported. Hreadyout must loop back to Hreadyin.
// ~~~~~~~~~~~~~~~~~~~~
module apbFsmController
(
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             valid,
	input  logic             Hwrite,
	input  logic             Hwritereg,
	input  bridgePkg::addr_t Haddr,
	input  bridgePkg::addr_t Haddr1,
	input  bridgePkg::addr_t Haddr2,
	input  bridgePkg::word_t Hwdata,
	input  bridgePkg::selx_t tempselx,
	output logic             Pwrite,
	output logic             Penable,
	output logic             Hreadyout,
	output bridgePkg::selx_t Pselx,
	output bridgePkg::addr_t Paddr,
	output bridgePkg::word_t Pwdata
);
	import bridgePkg::*;

	apbState_t state;
	apbState_t nextState;

	selx_t selReg; // select of the address held in Haddr1.

	logic  pwriteNxt;
	logic  penableNxt;
	logic  hreadyoutNxt;
	selx_t pselxNxt;
	addr_t paddrNxt;
	word_t pwdataNxt;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	// follows Haddr1 on every accepted transfer.
	always_ff @(posedge Hclk)
	begin
		if (valid)
			selReg <= tempselx;
	end

	always_comb
	begin
		case (state)
			stIdle, stREnable, stWEnable:
			begin
				if (!valid)
					nextState = stIdle;
				else if (Hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end

			stWwait:
			begin
				if (valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end

			stRead:
				nextState = stREnable;

			stWrite:
			begin
				if (valid)
					nextState = stWEnableP;
				else
					nextState = stWEnable;
			end

			stWriteP:
				nextState = stWEnableP;

			stWEnableP:
			begin
				if (!Hwritereg)
					nextState = stRead;
				else if (valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end

			default:
				nextState = stIdle;
		endcase
	end

	// outputs for the state being entered. Unassigned outputs hold.
	always_comb
	begin
		pwriteNxt    = Pwrite;
		penableNxt   = Penable;
		hreadyoutNxt = Hreadyout;
		pselxNxt     = Pselx;
		paddrNxt     = Paddr;
		pwdataNxt    = Pwdata;

		case (state)
			stIdle, stREnable, stWEnable:
			begin
				penableNxt = 1'b0;
				if (valid && !Hwrite)
				begin
					// read setup straight from the address phase.
					paddrNxt     = Haddr;
					pwriteNxt    = 1'b0;
					pselxNxt     = tempselx;
					hreadyoutNxt = 1'b0;
				end
				else
				begin
					pselxNxt     = '0;
					hreadyoutNxt = 1'b1;
				end
			end

			stWwait:
			begin
				paddrNxt     = Haddr1;
				pwdataNxt    = Hwdata; // data phase is on the bus now.
				pwriteNxt    = 1'b1;
				pselxNxt     = selReg;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b0;
			end

			stRead:
			begin
				penableNxt   = 1'b1;
				hreadyoutNxt = 1'b1;
			end

			stWrite:
			begin
				penableNxt   = 1'b1;
				hreadyoutNxt = !valid || Hwrite;
			end

			stWriteP:
			begin
				penableNxt   = 1'b1;
				hreadyoutNxt = Hwritereg; // a pending read waits for its setup.
			end

			stWEnableP:
			begin
				// setup for the transfer waiting in Haddr1.
				paddrNxt     = Haddr1;
				pwriteNxt    = Hwritereg;
				pselxNxt     = selReg;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b0;
				if (Hwritereg)
					pwdataNxt = Hwdata;
			end

			default:
			begin
				pselxNxt     = '0;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b1;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pwrite    <= 1'b0;
			Penable   <= 1'b0;
			Hreadyout <= 1'b0;
			Pselx     <= '0;
		end
		else
		begin
			Pwrite    <= pwriteNxt;
			Penable   <= penableNxt;
			Hreadyout <= hreadyoutNxt;
			Pselx     <= pselxNxt;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr  <= paddrNxt;
		Pwdata <= pwdataNxt;
	end

	enableHasSel: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> Pselx != '0);

	setupBeforeEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$rose(Penable) |-> $past(Pselx) == Pselx);

	addrStable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$rose(Penable) |-> $stable(Paddr) && $stable(Pwrite));

	// read enable drives the AHB data phase in the same cycle.
	readToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == stRead |=> state == stREnable && Penable && Hreadyout && !Pwrite);

	// on the write path the APB address is the older pipeline stage.
	writeAddrInPipe: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state inside {stWrite, stWriteP, stWEnable, stWEnableP} |-> Paddr == Haddr2);

endmodule

/* source/ahbSlaveInterface.sv */
// ~~~~~~~~~~~~~~~~~~~~
// AHB side of the bridge. Pipeline stages load only while Hreadyin is high.
// Only NONSEQ and SEQ transfers inside a window count as valid.
// ~~~~~~~~~~~~~~~~~~~~
`include "bridgeMacros_macros.svh"

module ahbSlaveInterface
(
	input  logic               Hclk,
	input  logic               Hresetn,
	input  bridgePkg::addr_t   Haddr,
	input  bridgePkg::word_t   Hwdata,
	input  logic               Hwrite,
	input  bridgePkg::htrans_t Htrans,
	input  logic               Hreadyin,
	output logic               valid,
	output bridgePkg::addr_t   Haddr1,
	output bridgePkg::addr_t   Haddr2,
	output bridgePkg::word_t   Hwdata1,
	output bridgePkg::word_t   Hwdata2,
	output logic               Hwritereg,
	output bridgePkg::selx_t   tempselx
);
	import bridgePkg::*;

	localparam addr_t slaveBase [`NUM_SLAVES] =
		'{`SLAVE0_BASE, `SLAVE1_BASE, `SLAVE2_BASE};

	logic transActive;
	logic inWindow;

	// window decode.
	always_comb
	begin
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			// unsigned wrap pushes addresses below the base out of range.
			tempselx[i] = (Haddr - slaveBase[i]) < `SLAVE_SPAN;
		end
	end

	assign inWindow    = |tempselx;
	assign transActive = (Htrans == NONSEQ) || (Htrans == SEQ);
	assign valid       = Hreadyin && transActive && inWindow;

	// address stages. Haddr2 trails Haddr1 by one accepted beat.
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			Haddr1 <= Haddr;
			Haddr2 <= Haddr1;
		end
	end

	// data stages.
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			Hwdata1 <= Hwdata;
			Hwdata2 <= Hwdata1;
		end
	end

	// direction of the last address phase.
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else if (Hreadyin)
			Hwritereg <= Hwrite;
	end

	// overlapping windows would break the one-hot select.
	validOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		valid |-> $onehot(tempselx));

endmodule

/* source/bridgePkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared bridge types. Widths come from the macro header.
// ~~~~~~~~~~~~~~~~~~~~
`include "bridgeMacros_macros.svh"

package bridgePkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`NUM_SLAVES-1:0] selx_t;

	// AHB Htrans encoding.
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// APB controller states.
	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stREnable  = 3'b101,
		stWEnable  = 3'b110,
		stWEnableP = 3'b111
	} apbState_t;

endpackage

/* source/bridgeMacros_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Bus widths and the three APB windows.
// Windows must not overlap, and each base is aligned to the span.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

`define NUM_SLAVES 3

// window bases in the AHB map.
`define SLAVE0_BASE 32'h8000_0000
`define SLAVE1_BASE 32'h8400_0000
`define SLAVE2_BASE 32'h8800_0000

// 64 MB per window.
`define SLAVE_SPAN 32'h0400_0000

`endif
